/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       := bex_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the pass message in the output
run: $(BIN)
	@out=$$(./$(BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
hdl/bex_pkg.sv
hdl/bex_ex_stage.sv
hdl/bex_data_ram.sv
hdl/bex_mem_stage.sv
hdl/bex_wb_stage.sv
hdl/bex_top.sv
tb/bex_tb.sv

/* hdl/bex_data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_data_ram import bex_pkg::*;
#(
  parameter int unsigned RAM_DEPTH = 64
) (
  input  logic                         clk,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr_i,
  input  logic [XLEN-1:0]              wdata_i,
  output logic [XLEN-1:0]              rdata_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One word per entry with no reset on the contents
  logic [XLEN-1:0] mem_q [RAM_DEPTH];
  logic [XLEN-1:0] rdata_q;

  // Single port access
  // The read register captures the old word when a write hits the same entry
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
      rdata_q <= mem_q[addr_i];
    end
  end

  // Read data appears one cycle after the enabled access
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hdl/bex_ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_ex_stage import bex_pkg::*;
#(
  parameter int unsigned RAM_DEPTH = 64,
  parameter int unsigned PROT_BASE = 48
) (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         instr_valid_i,
  input  instr_t       instr_i,
  output ex_mem_pipe_t ex_mem_pipe_o
);

  // Word address width of the data RAM
  // RAM_DEPTH is taken to be a power of two so the slice below is the modulo
  localparam int unsigned AW = $clog2(RAM_DEPTH);

  logic [XLEN-1:0] alu_result;
  logic [AW-1:0]   word_addr;
  logic [XLEN-1:0] mem_addr;
  logic            is_load;
  logic            is_store;
  logic            rf_we;
  mpu_status_e     mpu_status;
  ex_mem_pipe_t    ex_mem_pipe_q;

  ////////////////////////////////////////
  // Decode and ALU
  ////////////////////////////////////////

  assign is_load  = (instr_i.op == OP_LW);
  assign is_store = (instr_i.op == OP_SW);

  always_comb begin
    case (instr_i.op)
      OP_SUB:  alu_result = instr_i.operand_a - instr_i.operand_b;
      OP_AND:  alu_result = instr_i.operand_a & instr_i.operand_b;
      OP_XOR:  alu_result = instr_i.operand_a ^ instr_i.operand_b;
      // Loads and stores ignore the ALU result so they share the adder path
      default: alu_result = instr_i.operand_a + instr_i.operand_b;
    endcase
  end

  // Stores never write the register file and neither does destination zero
  assign rf_we = !is_store && (instr_i.rd != '0);

  ////////////////////////////////////////
  // Address and region check
  ////////////////////////////////////////

  // Operand A wraps onto the data RAM as a word address
  assign word_addr = instr_i.operand_a[AW-1:0];
  assign mem_addr  = XLEN'(word_addr);

  // Everything from PROT_BASE upward is protected
  // Only memory accesses can fault
  assign mpu_status = ((is_load || is_store) && (mem_addr >= XLEN'(PROT_BASE))) ?
                      MPU_FAULT : MPU_OK;

  ////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_mem_pipe_q.instr_valid <= 1'b0;
      ex_mem_pipe_q.rf_we       <= 1'b0;
      ex_mem_pipe_q.lsu_load    <= 1'b0;
      ex_mem_pipe_q.lsu_store   <= 1'b0;
      ex_mem_pipe_q.mpu_status  <= MPU_OK;
    end else begin
      // Control bits are qualified by the strobe every cycle
      ex_mem_pipe_q.instr_valid <= instr_valid_i;
      ex_mem_pipe_q.rf_we       <= instr_valid_i && rf_we;
      ex_mem_pipe_q.lsu_load    <= instr_valid_i && is_load;
      ex_mem_pipe_q.lsu_store   <= instr_valid_i && is_store;
      ex_mem_pipe_q.mpu_status  <= mpu_status;
      // Payload only moves when an instruction is accepted
      if (instr_valid_i) begin
        ex_mem_pipe_q.rd         <= instr_i.rd;
        ex_mem_pipe_q.alu_result <= alu_result;
        ex_mem_pipe_q.mem_addr   <= mem_addr;
        ex_mem_pipe_q.mem_wdata  <= instr_i.operand_b;
      end
    end
  end

  assign ex_mem_pipe_o = ex_mem_pipe_q;

  // The memory stage would issue a read and a write at once otherwise
  a_load_store_exclusive : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(ex_mem_pipe_q.lsu_load && ex_mem_pipe_q.lsu_store)
  );

endmodule

`default_nettype wire

/* hdl/bex_mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_mem_stage import bex_pkg::*;
#(
  parameter int unsigned RAM_DEPTH = 64
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_mem_pipe_t    ex_mem_pipe_i,
  output mem_wb_pipe_t    mem_wb_pipe_o,
  output logic [XLEN-1:0] lsu_rdata_o
);

  localparam int unsigned AW = $clog2(RAM_DEPTH);

  logic            ram_en;
  logic            ram_we;
  logic [AW-1:0]   ram_addr;
  logic            access_ok;
  mem_wb_pipe_t    mem_wb_pipe_q;

  ////////////////////////////////////////
  // Data RAM access
  ////////////////////////////////////////

  assign access_ok = (ex_mem_pipe_i.mpu_status == MPU_OK);

  // A faulted store is dropped here and never reaches the array
  assign ram_we = ex_mem_pipe_i.instr_valid && ex_mem_pipe_i.lsu_store && access_ok;

  // Loads read even when faulted since write-back discards the data
  assign ram_en = ram_we || (ex_mem_pipe_i.instr_valid && ex_mem_pipe_i.lsu_load);

  // Upper address bits are always zero after the wrap in execute
  assign ram_addr = ex_mem_pipe_i.mem_addr[AW-1:0];

  bex_data_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_data_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ex_mem_pipe_i.mem_wdata),
    .rdata_o (lsu_rdata_o)
  );

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem_wb_pipe_q.instr_valid <= 1'b0;
      mem_wb_pipe_q.rf_we       <= 1'b0;
      mem_wb_pipe_q.lsu_en      <= 1'b0;
      mem_wb_pipe_q.mpu_status  <= MPU_OK;
    end else begin
      mem_wb_pipe_q.instr_valid <= ex_mem_pipe_i.instr_valid;
      mem_wb_pipe_q.rf_we       <= ex_mem_pipe_i.rf_we;
      // Write-back takes its data from the RAM for loads
      mem_wb_pipe_q.lsu_en      <= ex_mem_pipe_i.lsu_load;
      mem_wb_pipe_q.mpu_status  <= ex_mem_pipe_i.mpu_status;
      if (ex_mem_pipe_i.instr_valid) begin
        mem_wb_pipe_q.rd       <= ex_mem_pipe_i.rd;
        mem_wb_pipe_q.rf_wdata <= ex_mem_pipe_i.alu_result;
      end
    end
  end

  assign mem_wb_pipe_o = mem_wb_pipe_q;

  // Every RAM write belongs to an unfaulted instruction that retires next cycle
  a_no_faulted_write : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ram_we |=> (mem_wb_pipe_q.instr_valid && (mem_wb_pipe_q.mpu_status == MPU_OK))
  );

endmodule

`default_nettype wire

/* hdl/bex_pkg.sv */
`default_nettype none

package bex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Width of every data word and operand
  localparam int unsigned XLEN = 32;

  // Register index into a 32-entry register file
  typedef logic [4:0] rf_addr_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Operation carried by each instruction
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_LW  = 3'd4,
    OP_SW  = 3'd5
  } op_e;

  // Result of the protected region check on a load or store
  typedef enum logic {
    MPU_OK    = 1'b0,
    MPU_FAULT = 1'b1
  } mpu_status_e;

  ////////////////////////////////////////
  // Pipeline records
  ////////////////////////////////////////

  // Instruction as it enters the execute stage
  typedef struct packed {
    op_e             op;
    rf_addr_t        rd;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } instr_t;

  // EX/MEM register contents
  // The rf_we bit is already low for stores and for rd zero
  typedef struct packed {
    logic            instr_valid;
    logic            rf_we;
    logic            lsu_load;
    logic            lsu_store;
    rf_addr_t        rd;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    mpu_status_e     mpu_status;
  } ex_mem_pipe_t;

  // MEM/WB register contents
  // Load data travels beside this record straight from the RAM
  typedef struct packed {
    logic            instr_valid;
    logic            rf_we;
    logic            lsu_en;
    rf_addr_t        rd;
    logic [XLEN-1:0] rf_wdata;
    mpu_status_e     mpu_status;
  } mem_wb_pipe_t;

endpackage

`default_nettype wire

/* hdl/bex_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_top import bex_pkg::*;
#(
  parameter int unsigned RAM_DEPTH = 64,
  parameter int unsigned PROT_BASE = 48
) (
  input  logic            clk,
  input  logic            rst_n_i,

  // Instruction strobe with no back-pressure
  input  logic            instr_valid_i,
  input  instr_t          instr_i,

  // Write-back outputs, two cycles after the strobe
  output logic            rf_we_o,
  output rf_addr_t        rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  output logic            wb_valid_o,
  output logic            lsu_fault_o
);

  ex_mem_pipe_t    ex_mem_pipe;
  mem_wb_pipe_t    mem_wb_pipe;
  logic [XLEN-1:0] lsu_rdata;

  ////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////

  // Execute owns the region check and needs both parameters
  bex_ex_stage #(
    .RAM_DEPTH (RAM_DEPTH),
    .PROT_BASE (PROT_BASE)
  ) i_ex_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .ex_mem_pipe_o (ex_mem_pipe)
  );

  // Memory passes the depth on to its RAM
  bex_mem_stage #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_mem_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ex_mem_pipe_i (ex_mem_pipe),
    .mem_wb_pipe_o (mem_wb_pipe),
    .lsu_rdata_o   (lsu_rdata)
  );

  bex_wb_stage i_wb_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .mem_wb_pipe_i (mem_wb_pipe),
    .lsu_rdata_i   (lsu_rdata),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o),
    .wb_valid_o    (wb_valid_o),
    .lsu_fault_o   (lsu_fault_o)
  );

endmodule

`default_nettype wire

/* hdl/bex_wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_wb_stage import bex_pkg::*;
(
  // Clock and reset only clock the assertion below
  input  logic            clk,
  input  logic            rst_n_i,

  // MEM/WB register and the RAM data beside it
  input  mem_wb_pipe_t    mem_wb_pipe_i,
  input  logic [XLEN-1:0] lsu_rdata_i,

  // Register file write port
  output logic            rf_we_o,
  output rf_addr_t        rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,

  // Retirement and fault flags
  output logic            wb_valid_o,
  output logic            lsu_fault_o
);

  logic fault;

  assign fault = (mem_wb_pipe_i.mpu_status == MPU_FAULT);

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  // A protection fault blocks the write even when rf_we came through
  assign rf_we_o    = mem_wb_pipe_i.instr_valid && mem_wb_pipe_i.rf_we && !fault;
  assign rf_waddr_o = mem_wb_pipe_i.rd;

  // Loads return RAM data and everything else returns the ALU result
  assign rf_wdata_o = mem_wb_pipe_i.lsu_en ? lsu_rdata_i : mem_wb_pipe_i.rf_wdata;

  ////////////////////////////////////////
  // Retirement
  ////////////////////////////////////////

  // One strobe per instruction, faulted ones included
  assign wb_valid_o = mem_wb_pipe_i.instr_valid;

  // Only loads and stores can carry a fault status
  assign lsu_fault_o = mem_wb_pipe_i.instr_valid && fault;

  // A register write retires an instruction whose destination execute found nonzero
  a_we_retires : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    rf_we_o |-> (wb_valid_o && (rf_waddr_o != '0) && !lsu_fault_o)
  );

endmodule

`default_nettype wire

/* tb/bex_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bex_tb
  import bex_pkg::*;
();

  localparam int unsigned RAM_DEPTH  = 64;
  localparam int unsigned PROT_BASE  = 48;
  localparam int unsigned AW         = $clog2(RAM_DEPTH);
  localparam int unsigned SEED       = 7534;
  localparam int unsigned NUM_PAIRS  = 12;
  localparam int unsigned NUM_RANDOM = 400;
  // Fill stores, directed store and load pairs, then the random mix
  localparam int unsigned NUM_INSTR  = PROT_BASE + 2 * NUM_PAIRS + NUM_RANDOM;
  // Random idle cycles can add up to one cycle per random instruction
  localparam int unsigned WATCHDOG_NS = NUM_INSTR * 10 + (NUM_RANDOM + 100) * 10;

  // Expected write-back for one retired instruction
  typedef struct packed {
    logic            valid;
    logic            we;
    logic            fault;
    rf_addr_t        waddr;
    logic [XLEN-1:0] wdata;
  } exp_t;

  logic            clk = 1'b0;
  logic            rst_n_i;
  logic            instr_valid_i;
  instr_t          instr_i;
  logic            rf_we_o;
  rf_addr_t        rf_waddr_o;
  logic [XLEN-1:0] rf_wdata_o;
  logic            wb_valid_o;
  logic            lsu_fault_o;

  // Mirror of the data RAM, left unknown until the fill stores land
  logic [XLEN-1:0] mirror [RAM_DEPTH];
  exp_t            pred_q [$];
  exp_t            exp_s1;
  exp_t            exp_s2;
  int              sent_count = 0;

  bex_top #(
    .RAM_DEPTH (RAM_DEPTH),
    .PROT_BASE (PROT_BASE)
  ) i_bex_top (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o),
    .wb_valid_o    (wb_valid_o),
    .lsu_fault_o   (lsu_fault_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic end_with_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    end_with_failure($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Works out the write-back of one instruction in program order
  // Stores update the mirror at once since later loads see them in order
  task automatic predict_instr(input instr_t ins);
    exp_t          e;
    logic [AW-1:0] word;
    logic          is_mem;
    word   = ins.operand_a[AW-1:0];
    is_mem = (ins.op == OP_LW) || (ins.op == OP_SW);
    e       = '0;
    e.valid = 1'b1;
    e.waddr = ins.rd;
    e.fault = is_mem && (32'(word) >= PROT_BASE);
    case (ins.op)
      OP_ADD:  e.wdata = ins.operand_a + ins.operand_b;
      OP_SUB:  e.wdata = ins.operand_a - ins.operand_b;
      OP_AND:  e.wdata = ins.operand_a & ins.operand_b;
      OP_XOR:  e.wdata = ins.operand_a ^ ins.operand_b;
      OP_LW:   e.wdata = mirror[word];
      default: e.wdata = '0;
    endcase
    // Stores, destination zero and faults never write a register
    e.we = (ins.op != OP_SW) && (ins.rd != '0) && !e.fault;
    if ((ins.op == OP_SW) && !e.fault) begin
      mirror[word] = ins.operand_b;
    end
    pred_q.push_back(e);
  endtask

  // Two stage delay line, so the head of the queue lines up with write-back
  always @(posedge clk) begin
    if (!rst_n_i) begin
      exp_s1 <= '0;
      exp_s2 <= '0;
    end else begin
      exp_s2 <= exp_s1;
      if (instr_valid_i) begin
        exp_s1 <= pred_q.pop_front();
      end else begin
        exp_s1 <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////

  a_wb_valid : assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_valid_o == exp_s2.valid)
    else report_mismatch("wb_valid_o", XLEN'($sampled(wb_valid_o)),
                         XLEN'($sampled(exp_s2.valid)));

  a_rf_we : assert property (@(posedge clk) disable iff (!rst_n_i)
    rf_we_o == exp_s2.we)
    else report_mismatch("rf_we_o", XLEN'($sampled(rf_we_o)), XLEN'($sampled(exp_s2.we)));

  a_lsu_fault : assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_fault_o == exp_s2.fault)
    else report_mismatch("lsu_fault_o", XLEN'($sampled(lsu_fault_o)),
                         XLEN'($sampled(exp_s2.fault)));

  // Address and data only matter when a write actually happens
  a_rf_waddr : assert property (@(posedge clk) disable iff (!rst_n_i)
    exp_s2.we |-> (rf_waddr_o == exp_s2.waddr))
    else report_mismatch("rf_waddr_o", XLEN'($sampled(rf_waddr_o)),
                         XLEN'($sampled(exp_s2.waddr)));

  a_rf_wdata : assert property (@(posedge clk) disable iff (!rst_n_i)
    exp_s2.we |-> (rf_wdata_o == exp_s2.wdata))
    else report_mismatch("rf_wdata_o", $sampled(rf_wdata_o), $sampled(exp_s2.wdata));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Drives one strobe; the next call can follow on the very next cycle
  task automatic send_instr(input instr_t ins);
    instr_i       = ins;
    instr_valid_i = 1'b1;
    predict_instr(ins);
    sent_count++;
    @(posedge clk);
    #1;
    instr_valid_i = 1'b0;
  endtask

  // Upper operand bits are random so the wrap onto the RAM gets exercised
  function automatic instr_t mem_instr(input op_e op, input logic [AW-1:0] word,
                                       input logic [XLEN-1:0] data);
    instr_t ins;
    ins.op                   = op;
    ins.rd                   = rf_addr_t'($urandom_range(1, 31));
    ins.operand_a            = $urandom();
    ins.operand_a[AW-1:0]    = word;
    ins.operand_b            = data;
    return ins;
  endfunction

  function automatic instr_t random_instr();
    instr_t ins;
    ins.op        = op_e'(3'($urandom_range(0, 5)));
    ins.rd        = ($urandom_range(0, 3) == 0) ? '0 : rf_addr_t'($urandom_range(1, 31));
    ins.operand_a = $urandom();
    ins.operand_b = $urandom();
    // About one access in four lands in the protected region
    if ((ins.op == OP_LW) || (ins.op == OP_SW)) begin
      if ($urandom_range(0, 3) == 0) begin
        ins.operand_a[AW-1:0] = AW'($urandom_range(PROT_BASE, RAM_DEPTH - 1));
      end else begin
        ins.operand_a[AW-1:0] = AW'($urandom_range(0, PROT_BASE - 1));
      end
    end
    return ins;
  endfunction

  initial begin
    logic [AW-1:0] word;
    void'($urandom(SEED));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    repeat (4) @(posedge clk);
    #1 rst_n_i = 1'b1;
    // Quiet pipeline after reset
    idle_cycles(6);
    // Define every unprotected word, back to back
    for (int unsigned i = 0; i < PROT_BASE; i++) begin
      send_instr(mem_instr(OP_SW, AW'(i), $urandom()));
    end
    // Load right behind a store, then the same into the protected region
    for (int unsigned i = 0; i < NUM_PAIRS; i++) begin
      if (i < NUM_PAIRS / 2) begin
        word = AW'($urandom_range(0, PROT_BASE - 1));
      end else begin
        word = AW'($urandom_range(PROT_BASE, RAM_DEPTH - 1));
      end
      send_instr(mem_instr(OP_SW, word, $urandom()));
      send_instr(mem_instr(OP_LW, word, $urandom()));
    end
    for (int unsigned i = 0; i < NUM_RANDOM; i++) begin
      send_instr(random_instr());
      if ($urandom_range(0, 4) == 0) begin
        idle_cycles(1);
      end
    end
    // Let the last instruction leave write-back
    idle_cycles(4);
    $display("TESTS PASSED");
    $finish;
  end

  // Watchdog against a stuck run
  initial begin
    #(WATCHDOG_NS);
    end_with_failure("Watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire
